/* all.f */
+incdir+bench
rtl/np_pkg.sv
rtl/lane_write_if.sv
rtl/lane_read_if.sv
rtl/flow_classifier.sv
rtl/lane_buffers.sv
rtl/out_arbiter.sv
rtl/np_core.sv
bench/tb_np_core.sv

/* bench/np_core_checks.svh */
// ##############################
// np core testbench checks
// lane reference, expected words, compares
// ##############################
`ifndef NP_CORE_CHECKS_SVH
`define NP_CORE_CHECKS_SVH

// expected words per lane, consumed from head to tail
data_word_t exp_data [NUM_LANES][EXP_MAX];
ctrl_t      exp_ctrl [NUM_LANES][EXP_MAX];
int         exp_head [NUM_LANES];
int         exp_tail [NUM_LANES];

// xor of all LANE_W-bit slices of the header, last slice may be short
function automatic logic [LANE_W-1:0] lane_of(input data_word_t hdr);
    logic [LANE_W-1:0] lane;
    int                pos;
    lane = '0;
    for (int s = 0; s * LANE_W < DATA_W; s++) begin
        for (int b = 0; b < LANE_W; b++) begin
            pos = s * LANE_W + b;
            if (pos < DATA_W)
                lane[b] = lane[b] ^ hdr[pos];
        end
    end
    return lane;
endfunction

task automatic push_expected(input int lane, input data_word_t d, input ctrl_t c);
    if (exp_tail[lane] == EXP_MAX) begin
        abort_run("expected word store ran out of space");
    end else begin
        exp_data[lane][exp_tail[lane]] = d;
        exp_ctrl[lane][exp_tail[lane]] = c;
        exp_tail[lane]++;
    end
endtask

task automatic check_data(input string name, input data_word_t got, input data_word_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

`endif

/* bench/tb_np_core.sv */
// ##############################
// np core testbench
// random packets, output stalls, lane back-pressure
// ##############################
module tb_np_core;
    import np_pkg::*;

    localparam int NUM_LANES      = 4;
    localparam int FIFO_DEPTH     = 16;
    localparam int LANE_W         = $clog2(NUM_LANES);
    localparam int N_RANDOM       = 40;
    localparam int N_FILL         = 3;
    localparam int N_PACKETS      = 1 + N_RANDOM + N_FILL;
    localparam int TIMEOUT_CYCLES = N_PACKETS * 8 * 20 + 500;
    localparam int EXP_MAX        = 1024;
    localparam int STAGE_MAX      = 64;
    localparam int RDY_HIGH       = 0;
    localparam int RDY_RANDOM     = 1;
    localparam int RDY_LOW        = 2;

    logic       clk;
    logic       rst_n;
    data_word_t in_data;
    ctrl_t      in_ctrl;
    logic       in_wr;
    logic       in_rdy;
    data_word_t out_data;
    ctrl_t      out_ctrl;
    logic       out_wr;
    logic       out_rdy;

    integer seed     = 28654;
    integer rdy_seed = 28654;
    int     rdy_mode = RDY_HIGH;
    int     cycle_count = 0;
    int     sent_words  = 0;
    int     rcv_words   = 0;

    // output side tracking, header picks the lane
    logic              in_pkt   = 1'b0;
    logic [LANE_W-1:0] cur_lane = '0;

    // words built but not yet driven
    data_word_t stage_data [STAGE_MAX];
    ctrl_t      stage_ctrl [STAGE_MAX];
    int         stage_cnt = 0;

    `include "np_core_checks.svh"

    np_core #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_np_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_data),
        .in_ctrl  (in_ctrl),
        .in_wr    (in_wr),
        .in_rdy   (in_rdy),
        .out_data (out_data),
        .out_ctrl (out_ctrl),
        .out_wr   (out_wr),
        .out_rdy  (out_rdy)
    );

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        stop_run();
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        out_rdy = 1'b1;
        forever begin
            @(negedge clk);
            case (rdy_mode)
                RDY_RANDOM: out_rdy = (($random(rdy_seed) & 3) != 0);
                RDY_LOW:    out_rdy = 1'b0;
                default:    out_rdy = 1'b1;
            endcase
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            abort_run("timeout, packets did not drain in time");
    end

    // compare each output word against the lane queue of its packet
    always @(posedge clk) begin
        if (rst_n && out_wr) begin
            if (!out_rdy) begin
                abort_run("out_wr was high while out_rdy was low");
            end else begin
                if (!in_pkt)
                    cur_lane = lane_of(out_data);
                if (exp_head[cur_lane] == exp_tail[cur_lane]) begin
                    abort_run($sformatf("unexpected word from lane %0d", cur_lane));
                end else begin
                    check_data("out_data", out_data, exp_data[cur_lane][exp_head[cur_lane]]);
                    check_ctrl("out_ctrl", out_ctrl, exp_ctrl[cur_lane][exp_head[cur_lane]]);
                    exp_head[cur_lane]++;
                    in_pkt = (out_ctrl == CTRL_HDR) || (out_ctrl == 8'h00);
                    rcv_words++;
                end
            end
        end
    end

    task automatic stage_word(input int lane, input data_word_t d, input ctrl_t c);
        stage_data[stage_cnt] = d;
        stage_ctrl[stage_cnt] = c;
        stage_cnt++;
        push_expected(lane, d, c);
    endtask

    task automatic build_packet(input int len, input int target);
        data_word_t        hdr;
        ctrl_t             tail;
        logic [LANE_W-1:0] lane;
        hdr  = {$random(seed), $random(seed)};
        // flip the low slice so the fold lands on target
        hdr[LANE_W-1:0] = hdr[LANE_W-1:0] ^ lane_of(hdr) ^ LANE_W'(target);
        lane = lane_of(hdr);
        tail = ctrl_t'(1 + {$random(seed)} % 254);
        stage_word(lane, hdr, CTRL_HDR);
        for (int i = 1; i < len; i++) begin
            stage_word(lane, {$random(seed), $random(seed)}, (i == len - 1) ? tail : 8'h00);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_word(input data_word_t d, input ctrl_t c, input int max_wait,
                             output bit taken);
        int waited;
        waited  = 0;
        in_data = d;
        in_ctrl = c;
        in_wr   = 1'b1;
        while (!in_rdy && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        taken = in_rdy;
        if (taken) begin
            @(negedge clk);
            sent_words++;
        end
        in_wr = 1'b0;
    endtask

    task automatic send_stage(input int first);
        bit taken;
        for (int i = first; i < stage_cnt; i++)
            send_word(stage_data[i], stage_ctrl[i], TIMEOUT_CYCLES, taken);
        stage_cnt = 0;
    endtask

    task automatic wait_drain();
        while (rcv_words != sent_words)
            @(negedge clk);
        // room for stray or duplicated words to show up
        repeat (20) @(negedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (exp_head[l] != exp_tail[l])
                abort_run($sformatf("lane %0d still has expected words left", l));
        end
    endtask

    initial begin
        bit taken;
        int first;
        in_data = '0;
        in_ctrl = '0;
        in_wr   = 1'b0;
        rst_n   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (!in_rdy)
            abort_run("in_rdy is low after reset");

        // one packet through an idle core
        build_packet(5, 2);
        send_stage(0);
        wait_drain();

        // random lengths over every lane with output stalls
        rdy_mode = RDY_RANDOM;
        for (int p = 0; p < N_RANDOM; p++) begin
            build_packet(2 + {$random(seed)} % 7,
                         (p < NUM_LANES) ? p : {$random(seed)} % NUM_LANES);
            send_stage(0);
        end
        wait_drain();

        // output held off, one lane fills up
        rdy_mode = RDY_LOW;
        repeat (2) @(negedge clk);
        for (int p = 0; p < N_FILL; p++)
            build_packet(8, 1);
        first = 0;
        taken = 1'b1;
        while (taken && first < stage_cnt) begin
            send_word(stage_data[first], stage_ctrl[first], 40, taken);
            if (taken)
                first++;
        end
        if (taken)
            abort_run("in_rdy never dropped with out_rdy held low");
        else if (first > FIFO_DEPTH + 1)
            abort_run($sformatf("%0d words taken into a full lane", first));
        rdy_mode = RDY_HIGH;
        send_stage(first);
        wait_drain();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* rtl/flow_classifier.sv */
// ##############################
// flow classifier
// tags word kinds, folds header into a lane
// ##############################
module flow_classifier #(
    parameter int NUM_LANES = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  np_pkg::data_word_t in_data,
    input  np_pkg::ctrl_t      in_ctrl,
    input  logic               in_wr,
    output logic               in_rdy,
    lane_write_if.cls          wr
);
    import np_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    cls_state_t        state;
    logic              take;
    data_word_t        data_q;
    ctrl_t             ctrl_q;
    word_kind_t        kind_q;
    logic [LANE_W-1:0] lane_q;

    // xor of all lane-width slices, bit i lands in position i mod LANE_W
    function automatic logic [LANE_W-1:0] fold_lane(input data_word_t d);
        logic [LANE_W-1:0] f;
        f = '0;
        for (int i = 0; i < DATA_W; i++) begin
            f[i % LANE_W] = f[i % LANE_W] ^ d[i];
        end
        return f;
    endfunction

    assign in_rdy = (state == CL_IDLE);
    assign take   = in_wr && in_rdy;

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= in_data;
            ctrl_q <= in_ctrl;
            kind_q <= kind_of(in_ctrl);
            // body and tail words reuse the lane of their header
            if (kind_of(in_ctrl) == WK_HEAD) begin
                lane_q <= fold_lane(in_data);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CL_IDLE;
        end else begin
            case (state)
                CL_IDLE: if (take) state <= CL_REQ;
                CL_REQ:  if (wr.ack) state <= CL_REL;
                // wait for ack low before taking the next word
                CL_REL:  if (!wr.ack) state <= CL_IDLE;
                default: state <= CL_IDLE;
            endcase
        end
    end

    assign wr.req  = (state == CL_REQ);
    assign wr.lane = lane_q;
    assign wr.data = data_q;
    assign wr.ctrl = ctrl_q;
    assign wr.kind = kind_q;

    // buffers must have released ack before a new request
    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(wr.req) |-> !wr.ack
    );

endmodule

/* rtl/lane_buffers.sv */
// ##############################
// lane buffers
// per-lane packet FIFOs with packet counts
// ##############################
module lane_buffers #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    lane_write_if.buffer wr,
    lane_read_if.buffer  rd
);
    import np_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = PTR_W + 1;

    data_word_t mem_data [NUM_LANES][FIFO_DEPTH];
    ctrl_t      mem_ctrl [NUM_LANES][FIFO_DEPTH];
    word_kind_t mem_kind [NUM_LANES][FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr  [NUM_LANES];
    logic [PTR_W-1:0] rd_ptr  [NUM_LANES];
    logic [CNT_W-1:0] fill    [NUM_LANES];
    logic [CNT_W-1:0] pkt_cnt [NUM_LANES];

    logic                 push;
    logic                 pop;
    logic                 grant_q;
    logic                 grant_fall;
    logic [NUM_LANES-1:0] lane_push;
    logic [NUM_LANES-1:0] lane_pop;
    logic [NUM_LANES-1:0] pkt_inc;
    logic [NUM_LANES-1:0] pkt_dec;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // store only when the target lane has room
    assign push = wr.req && !wr.ack && (fill[wr.lane] != CNT_W'(FIFO_DEPTH));
    // pop on the first cycle ack is seen
    assign pop        = rd.req && rd.ack;
    // end of a granted packet
    assign grant_fall = grant_q && !rd.grant_valid;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_push[l]    = push && (wr.lane == LANE_W'(l));
            lane_pop[l]     = pop && (rd.grant_lane == LANE_W'(l));
            pkt_inc[l]      = lane_push[l] && (wr.kind == WK_TAIL);
            pkt_dec[l]      = grant_fall && (rd.grant_lane == LANE_W'(l));
            rd.pkt_ready[l] = (pkt_cnt[l] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr.lane][wr_ptr[wr.lane]] <= wr.data;
            mem_ctrl[wr.lane][wr_ptr[wr.lane]] <= wr.ctrl;
            mem_kind[wr.lane][wr_ptr[wr.lane]] <= wr.kind;
        end
    end

    // head word of the granted lane
    assign rd.data = mem_data[rd.grant_lane][rd_ptr[rd.grant_lane]];
    assign rd.ctrl = mem_ctrl[rd.grant_lane][rd_ptr[rd.grant_lane]];
    assign rd.kind = mem_kind[rd.grant_lane][rd_ptr[rd.grant_lane]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.ack  <= 1'b0;
            rd.req  <= 1'b0;
            grant_q <= 1'b0;
            for (int l = 0; l < NUM_LANES; l++) begin
                wr_ptr[l]  <= '0;
                rd_ptr[l]  <= '0;
                fill[l]    <= '0;
                pkt_cnt[l] <= '0;
            end
        end else begin
            grant_q <= rd.grant_valid;
            if (push)
                wr.ack <= 1'b1;
            else if (!wr.req)
                wr.ack <= 1'b0;
            // next word once the previous handshake has closed
            if (pop)
                rd.req <= 1'b0;
            else if (rd.grant_valid && !rd.req && !rd.ack)
                rd.req <= 1'b1;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_push[l])
                    wr_ptr[l] <= next_ptr(wr_ptr[l]);
                if (lane_pop[l])
                    rd_ptr[l] <= next_ptr(rd_ptr[l]);
                if (lane_push[l] && !lane_pop[l])
                    fill[l] <= fill[l] + 1'b1;
                else if (!lane_push[l] && lane_pop[l])
                    fill[l] <= fill[l] - 1'b1;
                if (pkt_inc[l] && !pkt_dec[l])
                    pkt_cnt[l] <= pkt_cnt[l] + 1'b1;
                else if (!pkt_inc[l] && pkt_dec[l])
                    pkt_cnt[l] <= pkt_cnt[l] - 1'b1;
            end
        end
    end

    // arbiter only grants lanes holding a whole packet
    a_grant_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(rd.grant_valid) |-> (pkt_cnt[rd.grant_lane] != '0)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_ovf
        a_no_overflow: assert property (
            @(posedge clk) disable iff (!rst_n)
            fill[g] <= CNT_W'(FIFO_DEPTH)
        );
    end

endmodule

/* rtl/lane_read_if.sv */
// ##############################
// lane read channel
// grant and packet words, buffers to arbiter
// ##############################
interface lane_read_if #(
    parameter int NUM_LANES = 4
);
    import np_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    // one bit per lane with a complete packet stored
    logic [NUM_LANES-1:0] pkt_ready;

    logic                 grant_valid;
    logic [LANE_W-1:0]    grant_lane;

    // buffers request, arbiter acknowledges
    logic                 req;
    logic                 ack;
    data_word_t           data;
    ctrl_t                ctrl;
    word_kind_t           kind;

    modport buffer (
        output pkt_ready, req, data, ctrl, kind,
        input  grant_valid, grant_lane, ack
    );

    modport arb (
        input  pkt_ready, req, data, ctrl, kind,
        output grant_valid, grant_lane, ack
    );

endinterface

/* rtl/lane_write_if.sv */
// ##############################
// lane write channel
// classified words, classifier to lane buffers
// ##############################
interface lane_write_if #(
    parameter int NUM_LANES = 4
);
    import np_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    // four-phase req/ack, fields stable while req is high
    logic              req;
    logic              ack;
    logic [LANE_W-1:0] lane;
    data_word_t        data;
    ctrl_t             ctrl;
    word_kind_t        kind;

    modport cls (
        output req, lane, data, ctrl, kind,
        input  ack
    );

    modport buffer (
        input  req, lane, data, ctrl, kind,
        output ack
    );

endinterface

/* rtl/np_core.sv */
// ##############################
// np core top level
// classifier, lane buffers, output arbiter
// ##############################
module np_core #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  np_pkg::data_word_t in_data,
    input  np_pkg::ctrl_t      in_ctrl,
    input  logic               in_wr,
    output logic               in_rdy,
    output np_pkg::data_word_t out_data,
    output np_pkg::ctrl_t      out_ctrl,
    output logic               out_wr,
    input  logic               out_rdy
);
    import np_pkg::*;

    lane_write_if #(.NUM_LANES(NUM_LANES)) wr_bus ();
    lane_read_if  #(.NUM_LANES(NUM_LANES)) rd_bus ();

    flow_classifier #(.NUM_LANES(NUM_LANES)) i_flow_classifier (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_data (in_data),
        .in_ctrl (in_ctrl),
        .in_wr   (in_wr),
        .in_rdy  (in_rdy),
        .wr      (wr_bus.cls)
    );

    lane_buffers #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_lane_buffers (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_bus.buffer),
        .rd    (rd_bus.buffer)
    );

    out_arbiter #(.NUM_LANES(NUM_LANES)) i_out_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd       (rd_bus.arb),
        .out_rdy  (out_rdy),
        .out_data (out_data),
        .out_ctrl (out_ctrl),
        .out_wr   (out_wr)
    );

endmodule

/* rtl/np_pkg.sv */
// ##############################
// np shared definitions
// word types, control codes, FSM state encodings
// ##############################
package np_pkg;

    localparam int DATA_W = 64;
    localparam int CTRL_W = 8;

    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [CTRL_W-1:0] ctrl_t;

    // header marker, zero is a body word, anything else ends the packet
    localparam ctrl_t CTRL_HDR  = 8'hFF;
    localparam ctrl_t CTRL_BODY = 8'h00;

    typedef enum logic [1:0] {
        WK_HEAD,
        WK_BODY,
        WK_TAIL
    } word_kind_t;

    typedef enum logic [1:0] {
        CL_IDLE,
        CL_REQ,
        CL_REL
    } cls_state_t;

    typedef enum logic [1:0] {
        AR_PICK,
        AR_REQ_WAIT,
        AR_ACK_HOLD,
        AR_RELEASE
    } arb_state_t;

    function automatic word_kind_t kind_of(input ctrl_t c);
        if (c == CTRL_HDR)
            return WK_HEAD;
        if (c == CTRL_BODY)
            return WK_BODY;
        return WK_TAIL;
    endfunction

endpackage

/* rtl/out_arbiter.sv */
// ##############################
// output arbiter
// round robin over ready lanes, whole packets
// ##############################
module out_arbiter #(
    parameter int NUM_LANES = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    lane_read_if.arb           rd,
    input  logic               out_rdy,
    output np_pkg::data_word_t out_data,
    output np_pkg::ctrl_t      out_ctrl,
    output logic               out_wr
);
    import np_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    arb_state_t        state;
    logic              accept;
    logic              pend_q;
    logic              tail_q;
    logic              pick_found;
    logic [LANE_W-1:0] pick_lane;

    // search starts one past the lane granted last
    always_comb begin
        logic [LANE_W-1:0] cand;
        pick_found = 1'b0;
        pick_lane  = rd.grant_lane;
        for (int k = 1; k <= NUM_LANES; k++) begin
            cand = rd.grant_lane + LANE_W'(k);
            if (!pick_found && rd.pkt_ready[cand]) begin
                pick_found = 1'b1;
                pick_lane  = cand;
            end
        end
    end

    // take a word only when the output can take it
    assign accept = (state == AR_REQ_WAIT) && rd.req && out_rdy && !pend_q;

    assign rd.grant_valid = (state == AR_REQ_WAIT) || (state == AR_ACK_HOLD);
    assign rd.ack         = (state == AR_ACK_HOLD);
    assign out_wr         = pend_q && out_rdy;

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= rd.data;
            out_ctrl <= rd.ctrl;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= AR_PICK;
            rd.grant_lane <= '1;
            pend_q        <= 1'b0;
            tail_q        <= 1'b0;
        end else begin
            if (accept)
                pend_q <= 1'b1;
            else if (out_rdy)
                pend_q <= 1'b0;
            case (state)
                AR_PICK: begin
                    if (pick_found) begin
                        rd.grant_lane <= pick_lane;
                        state         <= AR_REQ_WAIT;
                    end
                end
                AR_REQ_WAIT: begin
                    if (accept) begin
                        tail_q <= (rd.kind == WK_TAIL);
                        state  <= AR_ACK_HOLD;
                    end
                end
                AR_ACK_HOLD: begin
                    if (!rd.req)
                        state <= tail_q ? AR_RELEASE : AR_REQ_WAIT;
                end
                // one idle cycle lets the lane count settle
                AR_RELEASE: state <= AR_PICK;
                default:    state <= AR_PICK;
            endcase
        end
    end

    // single-cycle write pulses, never into a stalled output
    a_out_wr_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_wr |-> out_rdy ##1 !out_wr
    );

endmodule
